/* Bender.yml */
package:
  name: lsm_step

sources:
  - fpga_cfg_pkg.sv
  - fx_mul_if.sv
  - fx_mul.sv
  - lsm_beta_regs.sv
  - lsm_decision.sv
  - lsm_pv_accum.sv
  - lsm_step_top.sv
  - target: simulation
    files:
      - tb_lsm_step.sv

/* fpga_cfg_pkg.sv */
`default_nettype none

package fpga_cfg_pkg;

    // fixed-point format, Q15.16 plus sign
    parameter int FP_WIDTH  = 32;
    parameter int FP_QINT   = 15;
    parameter int FP_QFRAC  = 16;

    parameter int ACC_WIDTH = 48;  // present-value sum
    parameter int CNT_WIDTH = 16;  // path counter

    // width of the intermediate values handed to fx_sat
    parameter int SAT_W = 2 * FP_WIDTH;

    // clamp a wide signed value into one FP_WIDTH word
    function automatic logic signed [FP_WIDTH-1:0] fx_sat(input logic signed [SAT_W-1:0] x);
        logic signed [SAT_W-1:0] max_v;
        logic signed [SAT_W-1:0] min_v;
        max_v = {{(SAT_W-FP_QINT-FP_QFRAC){1'b0}}, {(FP_QINT+FP_QFRAC){1'b1}}};
        min_v = ~max_v;  // most negative word
        if (x > max_v)
            return max_v[FP_WIDTH-1:0];
        else if (x < min_v)
            return min_v[FP_WIDTH-1:0];
        else
            return x[FP_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

/* fx_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module fx_mul #(
    parameter int WIDTH = fpga_cfg_pkg::FP_WIDTH,
    parameter int QFRAC = fpga_cfg_pkg::FP_QFRAC
)(
    input  wire logic clk,
    input  wire logic rst_n,
    fx_mul_if.slave   mul
);

    logic signed [2*WIDTH-1:0] prod;     // full double-width product
    logic signed [2*WIDTH-1:0] prod_sh;  // rescaled back to QFRAC

    always_comb begin
        prod    = mul.a * mul.b;
        prod_sh = prod >>> QFRAC;
    end

    // ------------------------------------------------------------
    // one register stage, frozen while en is low
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul.out_valid <= 1'b0;
        end else if (mul.en) begin
            mul.out_valid <= mul.in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mul.en) begin
            mul.result <= fpga_cfg_pkg::fx_sat(prod_sh);  // clamp on overflow
        end
    end

endmodule

`default_nettype wire

/* fx_mul_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fx_mul_if #(
    parameter int WIDTH = fpga_cfg_pkg::FP_WIDTH
);
    logic                    en;        // shared stall enable
    logic                    in_valid;
    logic signed [WIDTH-1:0] a;
    logic signed [WIDTH-1:0] b;
    logic                    out_valid;
    logic signed [WIDTH-1:0] result;

    // pipeline side, feeds operands
    modport master (
        output en, in_valid, a, b,
        input  out_valid, result
    );

    // multiplier side
    modport slave (
        input  en, in_valid, a, b,
        output out_valid, result
    );

endinterface

`default_nettype wire

/* lsm_beta_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module lsm_beta_regs #(
    parameter int WIDTH = fpga_cfg_pkg::FP_WIDTH
)(
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    beta_we,
    input  wire logic [1:0]              beta_sel,
    input  wire logic signed [WIDTH-1:0] beta_wdata,
    output logic signed [WIDTH-1:0]      beta0,
    output logic signed [WIDTH-1:0]      beta1,
    output logic signed [WIDTH-1:0]      beta2
);

    // regression result of one time step, reloaded by the host between steps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beta0 <= '0;
            beta1 <= '0;
            beta2 <= '0;
        end else if (beta_we) begin
            case (beta_sel)
                2'd0:    beta0 <= beta_wdata;  // constant term
                2'd1:    beta1 <= beta_wdata;  // linear in S
                2'd2:    beta2 <= beta_wdata;  // quadratic in S
                default: ;                     // sel 3 has no register
            endcase
        end
    end

endmodule

`default_nettype wire

/* lsm_decision.sv */
`timescale 1ns/1ps
`default_nettype none

module lsm_decision #(
    parameter int WIDTH = fpga_cfg_pkg::FP_WIDTH,
    parameter int QFRAC = fpga_cfg_pkg::FP_QFRAC
)(
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    in_valid,
    output logic                         in_ready,
    input  wire logic signed [WIDTH-1:0] s_t,
    input  wire logic signed [WIDTH-1:0] strike,
    input  wire logic signed [WIDTH-1:0] disc,
    input  wire logic signed [WIDTH-1:0] beta0,
    input  wire logic signed [WIDTH-1:0] beta1,
    input  wire logic signed [WIDTH-1:0] beta2,
    output logic                         out_valid,
    input  wire logic                    out_ready,
    output logic signed [WIDTH-1:0]      pv
);

    localparam int WW = fpga_cfg_pkg::SAT_W;

    logic advance;  // one stall enable for every stage

    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    // ------------------------------------------------------------
    // stage 1: input buffer, path plus coefficients
    // ------------------------------------------------------------
    logic                    s1_valid;
    logic signed [WIDTH-1:0] s1_s, s1_strike, s1_disc;
    logic signed [WIDTH-1:0] s1_b0, s1_b1, s1_b2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else if (advance)
            s1_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_s      <= s_t;
            s1_strike <= strike;
            s1_disc   <= disc;
            s1_b0     <= beta0;  // coefficients travel with the path
            s1_b1     <= beta1;
            s1_b2     <= beta2;
        end
    end

    // ------------------------------------------------------------
    // stages 2 and 3: multiplier chain
    // ------------------------------------------------------------
    fx_mul_if #(.WIDTH(WIDTH)) ss_if ();
    fx_mul_if #(.WIDTH(WIDTH)) b1s_if ();
    fx_mul_if #(.WIDTH(WIDTH)) b2s2_if ();

    assign ss_if.en       = advance;
    assign ss_if.in_valid = s1_valid;
    assign ss_if.a        = s1_s;
    assign ss_if.b        = s1_s;

    assign b1s_if.en       = advance;
    assign b1s_if.in_valid = s1_valid;
    assign b1s_if.a        = s1_b1;
    assign b1s_if.b        = s1_s;

    fx_mul #(.WIDTH(WIDTH), .QFRAC(QFRAC)) mul_s_s   (.clk(clk), .rst_n(rst_n), .mul(ss_if));
    fx_mul #(.WIDTH(WIDTH), .QFRAC(QFRAC)) mul_b1_s  (.clk(clk), .rst_n(rst_n), .mul(b1s_if));

    // side registers for stage 2
    logic signed [WIDTH-1:0] s2_s, s2_strike, s2_disc, s2_b0, s2_b2;

    always_ff @(posedge clk) begin
        if (advance) begin
            s2_s      <= s1_s;
            s2_strike <= s1_strike;
            s2_disc   <= s1_disc;
            s2_b0     <= s1_b0;
            s2_b2     <= s1_b2;
        end
    end

    assign b2s2_if.en       = advance;
    assign b2s2_if.in_valid = ss_if.out_valid && b1s_if.out_valid;  // both products landed
    assign b2s2_if.a        = s2_b2;
    assign b2s2_if.b        = ss_if.result;

    fx_mul #(.WIDTH(WIDTH), .QFRAC(QFRAC)) mul_b2_s2 (.clk(clk), .rst_n(rst_n), .mul(b2s2_if));

    // side registers for stage 3
    logic signed [WIDTH-1:0] s3_s, s3_strike, s3_disc, s3_b0, s3_b1s;

    always_ff @(posedge clk) begin
        if (advance) begin
            s3_s      <= s2_s;
            s3_strike <= s2_strike;
            s3_disc   <= s2_disc;
            s3_b0     <= s2_b0;
            s3_b1s    <= b1s_if.result;  // b1*S waits one stage for b2*S^2
        end
    end

    // ------------------------------------------------------------
    // stage 4: continuation value and payoff
    // ------------------------------------------------------------
    logic signed [WW-1:0]    c_sum_w;
    logic signed [WW-1:0]    diff_w;
    logic signed [WIDTH-1:0] payoff;

    always_comb begin
        c_sum_w = s3_b0 + s3_b1s + b2s2_if.result;  // sign-extended, no wrap
        diff_w  = s3_strike - s3_s;
        if (s3_strike > s3_s)
            payoff = fpga_cfg_pkg::fx_sat(diff_w);
        else
            payoff = '0;  // put out of the money
    end

    logic                    s4_valid;
    logic signed [WIDTH-1:0] s4_c, s4_payoff, s4_disc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s4_valid <= 1'b0;
        else if (advance)
            s4_valid <= b2s2_if.out_valid;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s4_c      <= fpga_cfg_pkg::fx_sat(c_sum_w);
            s4_payoff <= payoff;
            s4_disc   <= s3_disc;
        end
    end

    // ------------------------------------------------------------
    // stage 5: exercise or hold, into output register
    // ------------------------------------------------------------
    logic signed [2*WIDTH-1:0] disc_prod;
    logic signed [WIDTH-1:0]   hold_pv;

    always_comb begin
        disc_prod = s4_c * s4_disc;
        hold_pv   = fpga_cfg_pkg::fx_sat(disc_prod >>> QFRAC);  // discounted continuation
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (advance)
            out_valid <= s4_valid;
    end

    // pv only moves on advance, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (advance)
            pv <= (s4_payoff >= s4_c) ? s4_payoff : hold_pv;
    end

endmodule

`default_nettype wire

/* lsm_pv_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module lsm_pv_accum #(
    parameter int WIDTH = fpga_cfg_pkg::FP_WIDTH,
    parameter int ACC_W = fpga_cfg_pkg::ACC_WIDTH,
    parameter int CNT_W = fpga_cfg_pkg::CNT_WIDTH
)(
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    acc_clear,
    input  wire logic                    pv_fire,
    input  wire logic signed [WIDTH-1:0] pv,
    output logic signed [ACC_W-1:0]      pv_sum,
    output logic [CNT_W-1:0]             path_count
);

    logic signed [ACC_W-1:0] pv_ext;

    assign pv_ext = {{(ACC_W-WIDTH){pv[WIDTH-1]}}, pv};  // sign extension

    // ------------------------------------------------------------
    // running sum and count, host divides for the mean
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pv_sum     <= '0;
            path_count <= '0;
        end else if (acc_clear) begin
            // clear wins, a value leaving this cycle is dropped
            pv_sum     <= '0;
            path_count <= '0;
        end else if (pv_fire) begin
            pv_sum     <= pv_sum + pv_ext;       // wraps
            path_count <= path_count + 1'b1;    // wraps
        end
    end

endmodule

`default_nettype wire

/* lsm_step_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsm_step_top #(
    parameter int WIDTH = fpga_cfg_pkg::FP_WIDTH,
    parameter int QFRAC = fpga_cfg_pkg::FP_QFRAC,
    parameter int ACC_W = fpga_cfg_pkg::ACC_WIDTH,
    parameter int CNT_W = fpga_cfg_pkg::CNT_WIDTH
)(
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    // path input
    input  wire logic                    path_valid,
    output logic                         path_ready,
    input  wire logic signed [WIDTH-1:0] path_s,
    input  wire logic signed [WIDTH-1:0] path_strike,
    input  wire logic signed [WIDTH-1:0] path_disc,
    // coefficient write port
    input  wire logic                    beta_we,
    input  wire logic [1:0]              beta_sel,
    input  wire logic signed [WIDTH-1:0] beta_wdata,
    // value output
    output logic                         pv_valid,
    input  wire logic                    pv_ready,
    output logic signed [WIDTH-1:0]      pv,
    // accumulator
    input  wire logic                    acc_clear,
    output logic signed [ACC_W-1:0]      pv_sum,
    output logic [CNT_W-1:0]             path_count
);

    logic signed [WIDTH-1:0] beta0, beta1, beta2;
    logic                    pv_fire;

    assign pv_fire = pv_valid && pv_ready;  // output handshake

    lsm_beta_regs #(.WIDTH(WIDTH)) u_beta (
        .clk        (clk),
        .rst_n      (rst_n),
        .beta_we    (beta_we),
        .beta_sel   (beta_sel),
        .beta_wdata (beta_wdata),
        .beta0      (beta0),
        .beta1      (beta1),
        .beta2      (beta2)
    );

    lsm_decision #(.WIDTH(WIDTH), .QFRAC(QFRAC)) u_decision (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (path_valid),
        .in_ready  (path_ready),
        .s_t       (path_s),
        .strike    (path_strike),
        .disc      (path_disc),
        .beta0     (beta0),
        .beta1     (beta1),
        .beta2     (beta2),
        .out_valid (pv_valid),
        .out_ready (pv_ready),
        .pv        (pv)
    );

    lsm_pv_accum #(.WIDTH(WIDTH), .ACC_W(ACC_W), .CNT_W(CNT_W)) u_accum (
        .clk        (clk),
        .rst_n      (rst_n),
        .acc_clear  (acc_clear),
        .pv_fire    (pv_fire),
        .pv         (pv),
        .pv_sum     (pv_sum),
        .path_count (path_count)
    );

endmodule

`default_nettype wire

/* tb_lsm_step.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsm_step;

    localparam int W        = fpga_cfg_pkg::FP_WIDTH;
    localparam int QF       = fpga_cfg_pkg::FP_QFRAC;
    localparam int ACC_W    = fpga_cfg_pkg::ACC_WIDTH;
    localparam int CNT_W    = fpga_cfg_pkg::CNT_WIDTH;
    localparam int NUM_ROWS = 20;
    localparam int ONE      = 1 << QF;  // 1.0 in fixed point

    logic clk, rst_n;
    logic path_valid, path_ready, beta_we, pv_valid, pv_ready, acc_clear;
    logic signed [W-1:0] path_s, path_strike, path_disc, beta_wdata, pv;
    logic [1:0] beta_sel;
    logic signed [ACC_W-1:0] pv_sum;
    logic [CNT_W-1:0] path_count;

    // stimulus table with one path per row
    logic signed [W-1:0] row_b0[NUM_ROWS], row_b1[NUM_ROWS], row_b2[NUM_ROWS];
    logic signed [W-1:0] row_s[NUM_ROWS], row_k[NUM_ROWS], row_d[NUM_ROWS];
    logic [7:0]          row_stall[NUM_ROWS];  // pv_ready bit for each cycle

    logic signed [W-1:0]     exp_q[$];  // expected pv in acceptance order
    logic signed [ACC_W-1:0] exp_sum;
    integer                  seed;

    lsm_step_top uut (
        .clk(clk), .rst_n(rst_n),
        .path_valid(path_valid), .path_ready(path_ready), .path_s(path_s),
        .path_strike(path_strike), .path_disc(path_disc),
        .beta_we(beta_we), .beta_sel(beta_sel), .beta_wdata(beta_wdata),
        .pv_valid(pv_valid), .pv_ready(pv_ready), .pv(pv),
        .acc_clear(acc_clear), .pv_sum(pv_sum), .path_count(path_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic signed [W-1:0] clamp_word(input logic signed [2*W-1:0] x);
        logic signed [2*W-1:0] hi;
        logic signed [2*W-1:0] lo;
        hi = {{(W+1){1'b0}}, {(W-1){1'b1}}};  // largest word
        lo = -hi - 1;
        if (x > hi) return hi[W-1:0];
        if (x < lo) return lo[W-1:0];
        return x[W-1:0];
    endfunction

    function automatic logic signed [W-1:0] fixed_mul(input logic signed [W-1:0] a,
                                                      input logic signed [W-1:0] b);
        logic signed [2*W-1:0] p;
        p = a * b;
        return clamp_word(p >>> QF);
    endfunction

    function automatic logic signed [W-1:0] model_pv(input int r);
        logic signed [2*W-1:0] c_wide;
        logic signed [2*W-1:0] diff;
        logic signed [W-1:0]   c;
        logic signed [W-1:0]   payoff;
        c_wide = row_b0[r] + fixed_mul(row_b1[r], row_s[r])
               + fixed_mul(row_b2[r], fixed_mul(row_s[r], row_s[r]));
        c = clamp_word(c_wide);
        diff = row_k[r] - row_s[r];
        payoff = (row_k[r] > row_s[r]) ? clamp_word(diff) : '0;
        return (payoff >= c) ? payoff : fixed_mul(c, row_d[r]);  // exercise or hold
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_pv(input string name, input logic signed [W-1:0] exp_v,
                            input logic signed [W-1:0] act_v);
        if (act_v !== exp_v)
            report_failure($sformatf("CHECK FAILED at %0t ns: %s expected %0d got %0d",
                                     $time, name, exp_v, act_v));
    endtask

    task automatic check_sum(input string name, input logic signed [ACC_W-1:0] exp_v,
                             input logic signed [ACC_W-1:0] act_v);
        if (act_v !== exp_v)
            report_failure($sformatf("CHECK FAILED at %0t ns: %s expected %0d got %0d",
                                     $time, name, exp_v, act_v));
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] exp_v,
                               input logic [CNT_W-1:0] act_v);
        if (act_v !== exp_v)
            report_failure($sformatf("CHECK FAILED at %0t ns: %s expected %0d got %0d",
                                     $time, name, exp_v, act_v));
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
            report_failure($sformatf("CHECK FAILED at %0t ns: %s expected %b got %b",
                                     $time, name, exp_v, act_v));
    endtask

    task automatic build_table();
        // corner rows for deep ITM, OTM, negative C, hold and saturation
        row_b0[0] = ONE;
        row_s[0]  = 50 * ONE;
        row_k[0]  = 100 * ONE;
        row_b0[1] = 5 * ONE;
        row_s[1]  = 120 * ONE;
        row_k[1]  = 100 * ONE;
        row_b0[2] = -10 * ONE;
        row_s[2]  = 110 * ONE;
        row_k[2]  = 100 * ONE;
        row_b0[3] = 20 * ONE;
        row_s[3]  = 95 * ONE;
        row_k[3]  = 100 * ONE;
        row_b0[4] = '0;
        row_s[4]  = 32'h8001_0000;
        row_k[4]  = 32'h7fff_0000;
        for (int i = 0; i < 5; i++) begin
            row_b1[i]    = '0;
            row_b2[i]    = (i == 4) ? ONE : 0;  // S*S clamps on row 4
            row_d[i]     = 32'h0000_f333;       // about 0.95
            row_stall[i] = 8'hff;
        end
        for (int i = 5; i < NUM_ROWS; i++) begin
            if ((i - 5) % 5 == 0) begin  // new regression result
                row_b0[i] = $random(seed) % (20 * ONE);
                row_b1[i] = $random(seed) % (ONE / 2);
                row_b2[i] = $random(seed) % 256;
            end else begin
                row_b0[i] = row_b0[i-1];
                row_b1[i] = row_b1[i-1];
                row_b2[i] = row_b2[i-1];
            end
            row_s[i]     = 70 * ONE + ({$random(seed)} % (60 * ONE));
            row_k[i]     = 100 * ONE;
            row_d[i]     = 32'h0000_f000 + ({$random(seed)} % 4096);
            row_stall[i] = $random(seed) | 8'h01;
        end
    endtask

    task automatic wait_drain();
        @(negedge clk);
        path_valid = 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic write_coeffs(input int r);
        for (int sel = 0; sel < 4; sel++) begin
            @(negedge clk);
            beta_we    = 1'b1;
            beta_sel   = sel[1:0];
            beta_wdata = (sel == 0) ? row_b0[r] : (sel == 1) ? row_b1[r] :
                         (sel == 2) ? row_b2[r] : 32'hdead_beef;  // sel 3 ignored
        end
        @(negedge clk);
        beta_we = 1'b0;
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin : driver
        logic signed [W-1:0]     pv_exp;
        logic signed [ACC_W-1:0] pv_ext;
        rst_n       = 1'b0;
        path_valid  = 1'b0;
        path_s      = '0;
        path_strike = '0;
        path_disc   = '0;
        beta_we     = 1'b0;
        beta_sel    = '0;
        beta_wdata  = '0;
        pv_ready    = 1'b1;
        acc_clear   = 1'b0;
        exp_sum     = '0;
        seed        = 77;
        build_table();
        repeat (10) begin
            @(negedge clk);
            check_bit("pv_valid", 1'b0, pv_valid);
            check_bit("path_ready", 1'b1, path_ready);
            check_sum("pv_sum", '0, pv_sum);
            check_count("path_count", '0, path_count);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("pv_valid", 1'b0, pv_valid);
        check_bit("path_ready", 1'b1, path_ready);
        check_sum("pv_sum", '0, pv_sum);
        check_count("path_count", '0, path_count);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i == 0 || row_b0[i] != row_b0[i-1] || row_b1[i] != row_b1[i-1] ||
                row_b2[i] != row_b2[i-1]) begin
                wait_drain();
                write_coeffs(i);
            end
            @(negedge clk);
            path_valid  = 1'b1;
            path_s      = row_s[i];
            path_strike = row_k[i];
            path_disc   = row_d[i];
            do @(posedge clk); while (!path_ready);  // accepted on this edge
            pv_exp = model_pv(i);
            pv_ext = pv_exp;
            exp_q.push_back(pv_exp);
            exp_sum = exp_sum + pv_ext;
        end
        wait_drain();
        @(negedge clk);
        check_bit("pv_valid", 1'b0, pv_valid);  // nothing left in flight
        check_count("path_count", NUM_ROWS, path_count);
        check_sum("pv_sum", exp_sum, pv_sum);
        acc_clear = 1'b1;
        @(negedge clk);
        acc_clear = 1'b0;
        @(negedge clk);
        check_sum("pv_sum", '0, pv_sum);
        check_count("path_count", '0, path_count);
        $display("TESTBENCH PASSED");
        $finish;
    end

    // random back-pressure from the table
    initial begin : stall_drive
        int pat_row;
        int pat_bit;
        pat_row = 0;
        pat_bit = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            pv_ready = row_stall[pat_row][pat_bit];
            pat_bit  = (pat_bit + 1) % 8;
            if (pat_bit == 0) pat_row = (pat_row + 1) % NUM_ROWS;
        end
    end

    initial begin : monitor
        logic signed [W-1:0] held;
        logic                holding;
        holding = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (holding) begin  // frozen output must not move
                    check_bit("pv_valid", 1'b1, pv_valid);
                    check_pv("pv held", held, pv);
                end
                holding = 1'b0;
                if (pv_valid && pv_ready) begin
                    if (exp_q.size() == 0)
                        report_failure("an output arrived with no path outstanding");
                    check_pv("pv", exp_q.pop_front(), pv);
                end else if (pv_valid) begin
                    held    = pv;
                    holding = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_ROWS * 20 + 200) @(posedge clk);
        report_failure("timeout: outputs stopped arriving before all paths were checked");
    end

endmodule

`default_nettype wire

/* verilog.f */
fpga_cfg_pkg.sv
fx_mul_if.sv
fx_mul.sv
lsm_beta_regs.sv
lsm_decision.sv
lsm_pv_accum.sv
lsm_step_top.sv
tb_lsm_step.sv
